// ==== verilog/tv_consts.svh ====
// shared constants for the tv controller: bus bases, frame geometry, raster timing; include where needed
`ifndef TV_CONSTS_SVH
`define TV_CONSTS_SVH

// xbus decode bases, octal like the microcode listings
`define TV_FB_BASE       22'o17000000
`define TV_REG_BASE      22'o17377760

// frame buffer window, 768 x 896, 32 pixels per word
`define TV_WIN_WIDTH     768
`define TV_WIN_HEIGHT    896

// horizontal timing, clocks per field (1688 total)
`define TV_H_ACTIVE      1280
`define TV_H_FRONT       48
`define TV_H_SYNC        112
`define TV_H_BACK        248

// vertical timing, lines per field (1066 total)
`define TV_V_ACTIVE      1024
`define TV_V_FRONT       1
`define TV_V_SYNC        3
`define TV_V_BACK        38

// video memory word address width
`define TV_VRAM_AWIDTH   15

// control register bit positions
`define TV_INT_EN_BIT    3
`define TV_INT_FLAG_BIT  4

`endif

// ==== verilog/tv_pkg.sv ====
// struct and enum types shared by the tv controller RTL and its testbench; import where used
`include "tv_consts.svh"

package tv_pkg;

   // --------------------------------------------------
   // xbus side
   // --------------------------------------------------

   // cpu request, held stable while req is high
   typedef struct packed {
      logic [21:0] addr;
      logic [31:0] data;
      logic        req;
      logic        write;
   } xbus_req_t;

   // slave response
   typedef struct packed {
      logic [31:0] data;
      logic        ack;
      logic        decode;
      logic        interrupt;
   } xbus_rsp_t;

   // --------------------------------------------------
   // video memory port a
   // --------------------------------------------------

   typedef struct packed {
      logic [`TV_VRAM_AWIDTH-1:0] addr;
      logic [31:0]                data;
      logic                       write;
      logic                       read;
   } vram_cmd_t;

   typedef struct packed {
      logic [31:0] data;
      logic        ready;
      logic        done;
   } vram_rsp_t;

   // --------------------------------------------------
   // raster
   // --------------------------------------------------

   // shifter output, syncs active low
   typedef struct packed {
      logic pixel;
      logic hsync;
      logic vsync;
      logic de;
   } video_t;

   // timing flags, valid in the cycle of the counter value
   typedef struct packed {
      logic de;
      logic in_window;
      logic fetch;
      logic hsync;
      logic vsync;
   } scan_t;

   // bus access machine
   typedef enum logic [1:0] {
      IDLE,
      WRITE,
      READ,
      DONE
   } fb_state_t;

endpackage

// ==== verilog/xbus_tv.sv ====
// xbus slave of the tv controller: decodes frame buffer and control register, waits on vram
`timescale 1ns/1ps
`include "tv_consts.svh"

module xbus_tv
(
   input  logic              clk,
   input  logic              reset,
   input  tv_pkg::xbus_req_t bus_req,
   output tv_pkg::xbus_rsp_t bus_rsp,
   output tv_pkg::vram_cmd_t vram_cmd,
   input  tv_pkg::vram_rsp_t vram_rsp,
   input  logic              frame_start
);
   import tv_pkg::*;

   localparam logic [21:0] fb_base  = `TV_FB_BASE;
   localparam logic [21:0] reg_base = `TV_REG_BASE;

   fb_state_t   state;
   fb_state_t   state_next;
   logic        in_fb;
   logic        in_reg;
   logic        start_fb_write;
   logic        start_fb_read;
   logic        reg_write;
   logic        reg_read;
   logic        clear_int;
   logic        int_en;
   logic        int_flag;
   logic [31:0] reg_word;
   logic [31:0] rsp_data;

   // --------------------------------------------------
   // address decode
   // --------------------------------------------------

   // frame buffer: 32k word window, upper 7 bits
   assign in_fb  = bus_req.addr[21:15] == fb_base[21:15];
   // control register: 8 word slot, upper 19 bits
   assign in_reg = bus_req.addr[21:3] == reg_base[21:3];

   // requests only counted from idle
   assign start_fb_write = bus_req.req & in_fb & bus_req.write;
   assign start_fb_read  = bus_req.req & in_fb & ~bus_req.write;
   assign reg_write      = (state == IDLE) & bus_req.req & in_reg & bus_req.write;
   assign reg_read       = (state == IDLE) & bus_req.req & in_reg & ~bus_req.write;

   // --------------------------------------------------
   // access state machine
   // --------------------------------------------------

   always_comb
   begin
      state_next = state;
      case (state)
         IDLE:
         begin
            if (start_fb_write)
               state_next = WRITE;
            else if (start_fb_read)
               state_next = READ;
            else if (bus_req.req & in_reg)
               // register access needs no memory cycle
               state_next = DONE;
         end
         WRITE:
         begin
            if (vram_rsp.done)
               state_next = DONE;
         end
         READ:
         begin
            if (vram_rsp.ready)
               state_next = DONE;
         end
         DONE:
         begin
            // hold ack until the master lets go
            if (!bus_req.req)
               state_next = IDLE;
         end
         default:
            state_next = IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= IDLE;
      else
         state <= state_next;
   end

   // --------------------------------------------------
   // control register and frame interrupt
   // --------------------------------------------------

   // writing a one to the flag bit acknowledges it
   assign clear_int = reg_write & bus_req.data[`TV_INT_FLAG_BIT];

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         int_en   <= 1'b0;
         int_flag <= 1'b0;
      end
      else
      begin
         if (reg_write)
            int_en <= bus_req.data[`TV_INT_EN_BIT];
         // set beats clear
         if (frame_start)
            int_flag <= 1'b1;
         else if (clear_int)
            int_flag <= 1'b0;
      end
   end

   always_comb
   begin
      reg_word                   = '0;
      reg_word[`TV_INT_EN_BIT]   = int_en;
      reg_word[`TV_INT_FLAG_BIT] = int_flag;
   end

   // read data, captured once per access
   always_ff @(posedge clk)
   begin
      if (reg_read)
         rsp_data <= reg_word;
      else if ((state == READ) && vram_rsp.ready)
         rsp_data <= vram_rsp.data;
   end

   // --------------------------------------------------
   // outputs
   // --------------------------------------------------

   always_comb
   begin
      vram_cmd.addr  = bus_req.addr[`TV_VRAM_AWIDTH-1:0];
      vram_cmd.data  = bus_req.data;
      // one-cycle write strobe, read held through READ
      vram_cmd.write = state == WRITE;
      vram_cmd.read  = state == READ;
   end

   always_comb
   begin
      bus_rsp.data      = rsp_data;
      bus_rsp.ack       = state == DONE;
      bus_rsp.decode    = in_fb | in_reg;
      bus_rsp.interrupt = int_flag & int_en;
   end

   // memory never sees both strobes
   a_strobe_excl: assert property (@(posedge clk) disable iff (reset)
      !(vram_cmd.write && vram_cmd.read));

   // no ack without a request on the cycle before
   a_ack_after_req: assert property (@(posedge clk) disable iff (reset)
      bus_rsp.ack |-> $past(bus_req.req));

endmodule

// ==== verilog/tv_vram.sv ====
// dual-port video word memory: port a serves the xbus slave, port b feeds scan-out
`timescale 1ns/1ps
`include "tv_consts.svh"

module tv_vram
#(
   parameter int awidth = `TV_VRAM_AWIDTH
)
(
   input  logic              clk,
   input  logic              reset,
   input  tv_pkg::vram_cmd_t a_cmd,
   output tv_pkg::vram_rsp_t a_rsp,
   input  logic [awidth-1:0] b_addr,
   output logic [31:0]       b_data
);

   localparam int depth = 1 << awidth;

   logic [31:0] mem [0:depth-1];
   logic [31:0] a_rdata;
   logic        a_ready;

   // --------------------------------------------------
   // port a
   // --------------------------------------------------

   always_ff @(posedge clk)
   begin
      if (a_cmd.write)
         mem[a_cmd.addr] <= a_cmd.data;
      if (a_cmd.read)
         a_rdata <= mem[a_cmd.addr];
   end

   // ready pulses once for a held read
   always_ff @(posedge clk)
   begin
      if (reset)
         a_ready <= 1'b0;
      else
         a_ready <= a_cmd.read & ~a_ready;
   end

   always_comb
   begin
      a_rsp.data  = a_rdata;
      a_rsp.ready = a_ready;
      // writes land at the edge, so done answers at once
      a_rsp.done  = a_cmd.write;
   end

   // --------------------------------------------------
   // port b
   // --------------------------------------------------

   // free-running read, one cycle latency
   always_ff @(posedge clk)
   begin
      b_data <= mem[b_addr];
   end

   // a write never overlaps the tail of a read
   a_done_ready_excl: assert property (@(posedge clk) disable iff (reset)
      !(a_rsp.done && a_rsp.ready));

endmodule

// ==== verilog/tv_scan_timing.sv ====
// raster timing generator: pixel and line counters, active-low syncs, window and fetch flags
`timescale 1ns/1ps
`include "tv_consts.svh"

module tv_scan_timing
#(
   parameter int h_active   = `TV_H_ACTIVE,
   parameter int h_front    = `TV_H_FRONT,
   parameter int h_sync     = `TV_H_SYNC,
   parameter int h_back     = `TV_H_BACK,
   parameter int v_active   = `TV_V_ACTIVE,
   parameter int v_front    = `TV_V_FRONT,
   parameter int v_sync     = `TV_V_SYNC,
   parameter int v_back     = `TV_V_BACK,
   parameter int win_width  = `TV_WIN_WIDTH,
   parameter int win_height = `TV_WIN_HEIGHT
)
(
   input  logic          clk,
   input  logic          reset,
   output tv_pkg::scan_t scan,
   output logic          frame_start
);

   // field order per line: active, front porch, sync, back porch
   localparam int h_total      = h_active + h_front + h_sync + h_back;
   localparam int v_total      = v_active + v_front + v_sync + v_back;
   localparam int hw           = $clog2(h_total);
   localparam int vw           = $clog2(v_total);
   localparam int h_sync_start = h_active + h_front;
   localparam int h_sync_end   = h_sync_start + h_sync;
   localparam int v_sync_start = v_active + v_front;
   localparam int v_sync_end   = v_sync_start + v_sync;

   // window centred in the active area
   localparam int h_win_start  = (h_active - win_width) / 2;
   localparam int h_win_end    = h_win_start + win_width;
   localparam int v_win_start  = (v_active - win_height) / 2;
   localparam int v_win_end    = v_win_start + win_height;

   logic [hw-1:0] h_count;
   logic [vw-1:0] v_count;
   logic [hw-1:0] h_rel;
   logic          h_last;
   logic          v_last;
   logic          h_in_win;
   logic          v_in_win;

   // --------------------------------------------------
   // counters
   // --------------------------------------------------

   assign h_last = h_count == hw'(h_total - 1);
   assign v_last = v_count == vw'(v_total - 1);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         h_count <= '0;
         v_count <= '0;
      end
      else if (h_last)
      begin
         h_count <= '0;
         v_count <= v_last ? '0 : v_count + 1'b1;
      end
      else
         h_count <= h_count + 1'b1;
   end

   // --------------------------------------------------
   // flags, same cycle as the counters
   // --------------------------------------------------

   assign h_in_win = (h_count >= hw'(h_win_start)) && (h_count < hw'(h_win_end));
   assign v_in_win = (v_count >= vw'(v_win_start)) && (v_count < vw'(v_win_end));
   // column inside the window, low 5 bits pick the word boundary
   assign h_rel    = h_count - hw'(h_win_start);

   always_comb
   begin
      scan.de        = (h_count < hw'(h_active)) && (v_count < vw'(v_active));
      scan.in_window = h_in_win && v_in_win;
      scan.fetch     = h_in_win && v_in_win && (h_rel[4:0] == 5'd0);
      scan.hsync     = !((h_count >= hw'(h_sync_start)) && (h_count < hw'(h_sync_end)));
      scan.vsync     = !((v_count >= vw'(v_sync_start)) && (v_count < vw'(v_sync_end)));
   end

   // first pixel of the first line
   assign frame_start = (h_count == '0) && (v_count == '0);

   // blanking covers both sync intervals
   a_de_outside_sync: assert property (@(posedge clk) disable iff (reset)
      scan.de |-> (scan.hsync && scan.vsync));

endmodule

// ==== verilog/tv_pixel_shifter.sv ====
// scan-out shifter: fetches window words from vram port b, shifts pixels lsb first, delays syncs
`timescale 1ns/1ps
`include "tv_consts.svh"

module tv_pixel_shifter
#(
   parameter int awidth = `TV_VRAM_AWIDTH
)
(
   input  logic              clk,
   input  logic              reset,
   input  tv_pkg::scan_t     scan,
   input  logic              frame_start,
   output logic [awidth-1:0] vram_addr,
   input  logic [31:0]       vram_data,
   output tv_pkg::video_t    video
);
   import tv_pkg::*;

   logic [awidth-1:0] fetch_addr;
   scan_t             scan_d1;
   scan_t             scan_d2;
   logic [31:0]       shift_reg;

   // --------------------------------------------------
   // fetch address
   // --------------------------------------------------

   // words are consumed in raster order, one per fetch
   always_ff @(posedge clk)
   begin
      if (reset)
         fetch_addr <= '0;
      else if (frame_start)
         fetch_addr <= '0;
      else if (scan.fetch)
         fetch_addr <= fetch_addr + 1'b1;
   end

   // address goes out with the fetch, data back next cycle
   assign vram_addr = fetch_addr;

   // --------------------------------------------------
   // flag pipeline
   // --------------------------------------------------

   // d1 lines up with the returning word, d2 with its first pixel
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         scan_d1 <= '0;
         scan_d2 <= '0;
      end
      else
      begin
         scan_d1 <= scan;
         scan_d2 <= scan_d1;
      end
   end

   // --------------------------------------------------
   // shift register
   // --------------------------------------------------

   // load on the word arrival, else move next pixel to bit 0
   always_ff @(posedge clk)
   begin
      if (scan_d1.fetch)
         shift_reg <= vram_data;
      else
         shift_reg <= {1'b0, shift_reg[31:1]};
   end

   always_comb
   begin
      // margins stay black
      video.pixel = shift_reg[0] & scan_d2.in_window;
      video.hsync = scan_d2.hsync;
      video.vsync = scan_d2.vsync;
      video.de    = scan_d2.de;
   end

endmodule

// ==== verilog/tv_top.sv ====
// tv controller top: xbus slave, video memory, raster timing and pixel shifter wired together
`timescale 1ns/1ps
`include "tv_consts.svh"

module tv_top
#(
   parameter int h_active   = `TV_H_ACTIVE,
   parameter int h_front    = `TV_H_FRONT,
   parameter int h_sync     = `TV_H_SYNC,
   parameter int h_back     = `TV_H_BACK,
   parameter int v_active   = `TV_V_ACTIVE,
   parameter int v_front    = `TV_V_FRONT,
   parameter int v_sync     = `TV_V_SYNC,
   parameter int v_back     = `TV_V_BACK,
   parameter int win_width  = `TV_WIN_WIDTH,
   parameter int win_height = `TV_WIN_HEIGHT
)
(
   input  logic              clk,
   input  logic              reset,
   input  tv_pkg::xbus_req_t bus_req,
   output tv_pkg::xbus_rsp_t bus_rsp,
   output tv_pkg::video_t    video
);
   import tv_pkg::*;

   vram_cmd_t                  vram_cmd;
   vram_rsp_t                  vram_rsp;
   scan_t                      scan;
   logic                       frame_start;
   logic [`TV_VRAM_AWIDTH-1:0] b_addr;
   logic [31:0]                b_data;

   // --------------------------------------------------
   // bus side
   // --------------------------------------------------

   xbus_tv xbus_tv_inst (
      .clk         (clk),
      .reset       (reset),
      .bus_req     (bus_req),
      .bus_rsp     (bus_rsp),
      .vram_cmd    (vram_cmd),
      .vram_rsp    (vram_rsp),
      .frame_start (frame_start)
   );

   tv_vram #(
      .awidth (`TV_VRAM_AWIDTH)
   ) tv_vram_inst (
      .clk    (clk),
      .reset  (reset),
      .a_cmd  (vram_cmd),
      .a_rsp  (vram_rsp),
      .b_addr (b_addr),
      .b_data (b_data)
   );

   // --------------------------------------------------
   // scan-out side
   // --------------------------------------------------

   tv_scan_timing #(
      .h_active   (h_active),
      .h_front    (h_front),
      .h_sync     (h_sync),
      .h_back     (h_back),
      .v_active   (v_active),
      .v_front    (v_front),
      .v_sync     (v_sync),
      .v_back     (v_back),
      .win_width  (win_width),
      .win_height (win_height)
   ) tv_scan_timing_inst (
      .clk         (clk),
      .reset       (reset),
      .scan        (scan),
      .frame_start (frame_start)
   );

   tv_pixel_shifter #(
      .awidth (`TV_VRAM_AWIDTH)
   ) tv_pixel_shifter_inst (
      .clk         (clk),
      .reset       (reset),
      .scan        (scan),
      .frame_start (frame_start),
      .vram_addr   (b_addr),
      .vram_data   (b_data),
      .video       (video)
   );

endmodule

// ==== tests/tv_tb.sv ====
// testbench for the tv controller on a tiny raster; run as top module tv_tb from all.f
`timescale 1ns/1ps
`include "tv_consts.svh"

module tv_tb;
   import tv_pkg::*;

   // --------------------------------------------------
   // reduced raster and window
   // --------------------------------------------------

   localparam int h_active   = 64;
   localparam int h_front    = 2;
   localparam int h_sync     = 4;
   localparam int h_back     = 6;
   localparam int v_active   = 8;
   localparam int v_front    = 1;
   localparam int v_sync     = 1;
   localparam int v_back     = 1;
   localparam int win_width  = 32;
   localparam int win_height = 4;

   localparam int h_total   = h_active + h_front + h_sync + h_back;
   localparam int v_total   = v_active + v_front + v_sync + v_back;
   localparam int frame_len = h_total * v_total;
   // window centred in the active area
   localparam int win_x0    = (h_active - win_width) / 2;
   localparam int win_y0    = (v_active - win_height) / 2;

   localparam int ack_limit     = 16;
   localparam int no_ack_cycles = 16;

   localparam logic [21:0] fb_base   = `TV_FB_BASE;
   localparam logic [21:0] reg_base  = `TV_REG_BASE;
   // colour probe window, deliberately not decoded
   localparam logic [21:0] probe_adr = 22'o17200000;
   localparam logic [31:0] en_bit    = 32'h1 << `TV_INT_EN_BIT;
   localparam logic [31:0] flag_bit  = 32'h1 << `TV_INT_FLAG_BIT;
   localparam logic [31:0] reg_mask  = en_bit | flag_bit;

   logic      clk;
   logic      reset;
   xbus_req_t bus_req;
   xbus_rsp_t bus_rsp;
   video_t    video;

   // bookkeeping
   string       test_name;
   int          fail_count;
   int          fails_at_start;
   int          tests_run;
   int          tests_failed;
   int          exp_lat;
   logic [31:0] exp_data;
   logic [31:0] exp_mask;
   logic        check_data;
   logic        exp_decode;
   logic        model_en;
   int          wait_count;
   int          scan_pos;
   int          run_cycles;
   logic        scan_armed;
   logic        pix_check;
   int          frames_checked;
   logic [3:0]  seen_state;
   int          fb_offsets [0:4];
   logic [31:0] fb_words [0:4];
   logic [31:0] scan_word [0:3];

   // expected raster at the shifter output
   int          vid_pos;
   int          vh;
   int          vv;
   logic        exp_de;
   logic        exp_hsync;
   logic        exp_vsync;
   logic        exp_in_win;
   logic        exp_pixel;

   initial
      clk = 1'b0;

   always #20 clk = ~clk;

   tv_top #(
      .h_active   (h_active),
      .h_front    (h_front),
      .h_sync     (h_sync),
      .h_back     (h_back),
      .v_active   (v_active),
      .v_front    (v_front),
      .v_sync     (v_sync),
      .v_back     (v_back),
      .win_width  (win_width),
      .win_height (win_height)
   ) tv_top_inst (
      .clk     (clk),
      .reset   (reset),
      .bus_req (bus_req),
      .bus_rsp (bus_rsp),
      .video   (video)
   );

   // --------------------------------------------------
   // reference counters
   // --------------------------------------------------

   // scan_pos mirrors the raster counters, video lags 2 cycles
   always @(posedge clk)
   begin
      if (reset)
      begin
         scan_pos       <= 0;
         run_cycles     <= 0;
         wait_count     <= 0;
         pix_check      <= 1'b0;
         frames_checked <= 0;
         seen_state     <= '0;
      end
      else
      begin
         scan_pos <= (scan_pos + 1) % frame_len;
         if (run_cycles < 2)
            run_cycles <= run_cycles + 1;
         // cycles with req up and no ack yet
         if (!bus_req.req)
            wait_count <= 0;
         else if (!bus_rsp.ack)
            wait_count <= wait_count + 1;
         // pixel checks start on a frame boundary
         if (scan_armed && vid_pos == 0)
            pix_check <= 1'b1;
         if (pix_check && vid_pos == frame_len - 1)
            frames_checked <= frames_checked + 1;
         seen_state[int'(tv_top_inst.xbus_tv_inst.state)] <= 1'b1;
      end
   end

   always_comb
   begin
      vid_pos    = (scan_pos + frame_len - 2) % frame_len;
      vh         = vid_pos % h_total;
      vv         = vid_pos / h_total;
      exp_de     = (vh < h_active) && (vv < v_active);
      // active-low syncs after the front porch
      exp_hsync  = !((vh >= h_active + h_front) && (vh < h_active + h_front + h_sync));
      exp_vsync  = !((vv >= v_active + v_front) && (vv < v_active + v_front + v_sync));
      exp_in_win = (vh >= win_x0) && (vh < win_x0 + win_width)
                   && (vv >= win_y0) && (vv < win_y0 + win_height);
      exp_pixel  = 1'b0;
      // one word per window line, lsb first
      if (exp_in_win)
         exp_pixel = scan_word[vv - win_y0][vh - win_x0];
   end

   // --------------------------------------------------
   // reporting and bus tasks
   // --------------------------------------------------

   task automatic report_mismatch(input string what, input logic [31:0] exp,
                                  input logic [31:0] act);
      fail_count++;
      $display("error %s: %s expected %0h, actual %0h", test_name, what, exp, act);
   endtask

   task automatic report_failure(input string what);
      fail_count++;
      $display("error %s: %s", test_name, what);
   endtask

   task automatic abort_run(input string what);
      $display("%s: %s", test_name, what);
      $display("Result: FAILED");
      $finish;
   endtask

   task automatic start_test(input string name);
      test_name      = name;
      fails_at_start = fail_count;
   endtask

   task automatic finish_test();
      tests_run++;
      if (fail_count == fails_at_start)
         $display("test %s: pass", test_name);
      else
      begin
         tests_failed++;
         $display("test %s: fail, %0d errors", test_name, fail_count - fails_at_start);
      end
   endtask

   // one req/ack cycle with the expected ack latency and read data
   task automatic bus_access(input logic [21:0] addr, input logic write,
                             input logic [31:0] data, input int lat,
                             input logic [31:0] exp, input logic [31:0] mask);
      int n;
      exp_lat    = lat;
      exp_data   = exp & mask;
      exp_mask   = mask;
      check_data = !write;
      exp_decode = 1'b1;
      @(posedge clk);
      #1;
      bus_req.addr  = addr;
      bus_req.data  = data;
      bus_req.write = write;
      bus_req.req   = 1'b1;
      n = 0;
      do
      begin
         @(posedge clk);
         #1;
         n++;
      end
      while (!bus_rsp.ack && n < ack_limit);
      if (!bus_rsp.ack)
         abort_run($sformatf("timeout, no ack from address %o", addr));
      // register write takes the enable in the same edge as ack
      if (write && addr == reg_base)
         model_en = data[`TV_INT_EN_BIT];
      bus_req.req = 1'b0;
      n = 0;
      do
      begin
         @(posedge clk);
         #1;
         n++;
      end
      while (bus_rsp.ack && n < ack_limit);
      if (bus_rsp.ack)
         abort_run("timeout, ack stayed high after req was dropped");
   endtask

   task automatic check_no_ack(input logic [21:0] addr);
      int   n;
      logic acked;
      exp_decode = 1'b0;
      check_data = 1'b0;
      @(posedge clk);
      #1;
      bus_req.addr  = addr;
      bus_req.write = 1'b0;
      bus_req.req   = 1'b1;
      n     = 0;
      acked = 1'b0;
      while (n < no_ack_cycles && !acked)
      begin
         @(posedge clk);
         #1;
         n++;
         if (bus_rsp.ack)
            acked = 1'b1;
      end
      bus_req.req = 1'b0;
      if (acked)
         report_failure($sformatf("undecoded address %o was acknowledged", addr));
      else
         $display("%s: no ack as expected from address %o", test_name, addr);
      @(posedge clk);
      #1;
      exp_decode = 1'b1;
   endtask

   task automatic wait_scan_pos(input int target);
      int n;
      n = 0;
      do
      begin
         @(posedge clk);
         #1;
         n++;
      end
      while (scan_pos != target && n < frame_len + 10);
      if (scan_pos != target)
         abort_run("timeout waiting for raster position");
   endtask

   task automatic wait_frames(input int count);
      int n;
      n = 0;
      while (frames_checked < count && n < (count + 1) * frame_len + 10)
      begin
         @(posedge clk);
         #1;
         n++;
      end
      if (frames_checked < count)
         abort_run("timeout waiting for checked frames");
   endtask

   // --------------------------------------------------
   // checks
   // --------------------------------------------------

   a_ack_latency: assert property (@(posedge clk) disable iff (reset)
      $rose(bus_rsp.ack) |-> wait_count == exp_lat)
      else report_mismatch("ack latency", $sampled(exp_lat), $sampled(wait_count));

   a_read_data: assert property (@(posedge clk) disable iff (reset)
      $rose(bus_rsp.ack) && check_data |-> (bus_rsp.data & exp_mask) == exp_data)
      else report_mismatch("read data", $sampled(exp_data),
                           $sampled(bus_rsp.data & exp_mask));

   a_decode: assert property (@(posedge clk) disable iff (reset)
      bus_req.req |-> bus_rsp.decode == exp_decode)
      else report_mismatch("decode", $sampled(exp_decode), $sampled(bus_rsp.decode));

   a_no_ack: assert property (@(posedge clk) disable iff (reset)
      !exp_decode |-> !bus_rsp.ack)
      else report_failure("ack raised for an undecoded address");

   // interrupt gated by the enable
   a_irq_gate: assert property (@(posedge clk) disable iff (reset)
      !model_en |-> !bus_rsp.interrupt)
      else report_mismatch("interrupt", 0, $sampled(bus_rsp.interrupt));

   // flag set by the frame start one edge earlier
   a_irq_frame: assert property (@(posedge clk) disable iff (reset)
      scan_pos == 1 && model_en |-> bus_rsp.interrupt)
      else report_mismatch("frame interrupt", 1, $sampled(bus_rsp.interrupt));

   a_de_timing: assert property (@(posedge clk) disable iff (reset)
      run_cycles >= 2 |-> video.de == exp_de)
      else report_mismatch("de", $sampled(exp_de), $sampled(video.de));

   a_hsync_timing: assert property (@(posedge clk) disable iff (reset)
      run_cycles >= 2 |-> video.hsync == exp_hsync)
      else report_mismatch("hsync", $sampled(exp_hsync), $sampled(video.hsync));

   a_vsync_timing: assert property (@(posedge clk) disable iff (reset)
      run_cycles >= 2 |-> video.vsync == exp_vsync)
      else report_mismatch("vsync", $sampled(exp_vsync), $sampled(video.vsync));

   a_hsync_de: assert property (@(posedge clk) disable iff (reset)
      !(video.de && !video.hsync))
      else report_failure("de overlaps hsync");

   // margins black even before the memory is written
   a_margin: assert property (@(posedge clk) disable iff (reset)
      run_cycles >= 2 && !exp_in_win |-> !video.pixel)
      else report_mismatch("margin pixel", 0, $sampled(video.pixel));

   a_pixel: assert property (@(posedge clk) disable iff (reset)
      pix_check && exp_in_win |-> video.pixel == exp_pixel)
      else report_mismatch($sformatf("pixel at %0d,%0d", $sampled(vh), $sampled(vv)),
                           $sampled(exp_pixel), $sampled(video.pixel));

   // --------------------------------------------------
   // test sequence
   // --------------------------------------------------

   initial
   begin
      reset          = 1'b1;
      bus_req        = '0;
      test_name      = "reset";
      fail_count     = 0;
      fails_at_start = 0;
      tests_run      = 0;
      tests_failed   = 0;
      exp_lat        = 0;
      exp_data       = '0;
      exp_mask       = '0;
      check_data     = 1'b0;
      exp_decode     = 1'b1;
      model_en       = 1'b0;
      scan_armed     = 1'b0;
      fb_offsets     = '{5, 100, 4095, 17000, 21503};
      for (int r = 0; r < 4; r++)
         scan_word[r] = '0;
      void'($urandom(24));
      repeat (8)
         @(posedge clk);
      #1;
      reset = 1'b0;

      // write then read back, 2 and 3 cycle acks
      start_test("fb_write_read");
      for (int i = 0; i < 5; i++)
      begin
         fb_words[i] = $urandom();
         bus_access(fb_base + 22'(fb_offsets[i]), 1'b1, fb_words[i], 2, '0, '0);
      end
      for (int i = 0; i < 5; i++)
         bus_access(fb_base + 22'(fb_offsets[i]), 1'b0, '0, 3, fb_words[i], '1);
      finish_test();

      // flag set by the first frame start, enable still off
      start_test("decode");
      bus_access(fb_base + 22'(fb_offsets[0]), 1'b0, '0, 3, fb_words[0], '1);
      bus_access(reg_base, 1'b0, '0, 1, flag_bit, reg_mask);
      check_no_ack(probe_adr);
      finish_test();

      // flag already set by the first frame start
      start_test("control_reg");
      wait_scan_pos(200);
      bus_access(reg_base, 1'b1, en_bit, 1, '0, '0);
      bus_access(reg_base, 1'b0, '0, 1, en_bit | flag_bit, reg_mask);
      bus_access(reg_base, 1'b1, en_bit | flag_bit, 1, '0, '0);
      bus_access(reg_base, 1'b0, '0, 1, en_bit, reg_mask);
      finish_test();

      start_test("frame_irq");
      wait_scan_pos(2);
      bus_access(reg_base, 1'b0, '0, 1, en_bit | flag_bit, reg_mask);
      // disable and clear, next frame sets the flag silently
      bus_access(reg_base, 1'b1, flag_bit, 1, '0, '0);
      wait_scan_pos(2);
      bus_access(reg_base, 1'b0, '0, 1, flag_bit, reg_mask);
      finish_test();

      // one word per window line at offsets 0..3
      start_test("scan_out");
      for (int r = 0; r < 4; r++)
      begin
         scan_word[r] = $urandom();
         bus_access(fb_base + 22'(r), 1'b1, scan_word[r], 2, '0, '0);
      end
      scan_armed = 1'b1;
      wait_frames(2);
      finish_test();

      $display("bus states seen: idle %0b, write %0b, read %0b, done %0b",
               seen_state[int'(IDLE)], seen_state[int'(WRITE)],
               seen_state[int'(READ)], seen_state[int'(DONE)]);
      $display("tests run %0d, tests failed %0d, check errors %0d",
               tests_run, tests_failed, fail_count);
      if (fail_count == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

// ==== all.f ====
+incdir+verilog
verilog/tv_pkg.sv
verilog/xbus_tv.sv
verilog/tv_vram.sv
verilog/tv_scan_timing.sv
verilog/tv_pixel_shifter.sv
verilog/tv_top.sv
tests/tv_tb.sv

// ==== Bender.yml ====
package:
  name: tv_display

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/tv_pkg.sv
      - verilog/xbus_tv.sv
      - verilog/tv_vram.sv
      - verilog/tv_scan_timing.sv
      - verilog/tv_pixel_shifter.sv
      - verilog/tv_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/tv_tb.sv
